// File: include/corr_macros.svh
`ifndef CORR_MACROS_SVH
`define CORR_MACROS_SVH

// Signed baseband sample from the front end.
`define CORR_SAMPLE_WIDTH 3

// Signed cosine and sine table values.
`define CORR_LUT_WIDTH 3

// Sample times table value.
`define CORR_PROD_WIDTH 6

// Carrier phase accumulator and increment.
`define CORR_PHASE_WIDTH 16
`define CORR_DOPPLER_WIDTH 10
`define CORR_F_IF_INC 16'h2000

// Code NCO accumulator and increment.
`define CORR_CODE_PHASE_WIDTH 16

// Integrators and the saturated result.
`define CORR_ACC_WIDTH 20
`define CORR_OUT_WIDTH 16

`endif

// File: src/corr_pkg.sv
`default_nettype none

`include "corr_macros.svh"

package corr_pkg;

   // One sample in flight through the channel.
   typedef struct packed {
      logic signed [`CORR_SAMPLE_WIDTH-1:0] data;
      logic                                 last;
   } sample_t;

   // PRN selection as two G2 stage numbers, 1 to 10.
   typedef struct packed {
      logic [3:0] tap_a;
      logic [3:0] tap_b;
   } ca_taps_t;

   // Carrier-wiped sample with its code chip.
   typedef struct packed {
      logic                               valid;
      logic                               last;
      logic                               ca_bit;
      logic signed [`CORR_PROD_WIDTH-1:0] prod_i;
      logic signed [`CORR_PROD_WIDTH-1:0] prod_q;
   } mixed_t;

   // Dumped and saturated correlation result.
   typedef struct packed {
      logic signed [`CORR_OUT_WIDTH-1:0] corr_i;
      logic signed [`CORR_OUT_WIDTH-1:0] corr_q;
   } corr_result_t;

endpackage

`default_nettype wire

// File: src/sample_front.sv
`timescale 1ns/1ps
`default_nettype none

`include "corr_macros.svh"

module sample_front
   import corr_pkg::*;
(
   input  logic                                 clk,
   input  logic                                 rst_n_i,
   input  logic                                 clear_i,
   input  logic                                 sample_valid_i,
   input  logic                                 sample_last_i,
   input  logic signed [`CORR_SAMPLE_WIDTH-1:0] sample_i,
   output logic                                 sample_valid_o,
   output sample_t                              sample_o
);

   logic    valid_q;
   sample_t sample_q;

   // Strobe register. Clear drops it.
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
      end else if (clear_i) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= sample_valid_i;
      end
   end

   // Sample payload rides along with the strobe.
   always_ff @(posedge clk) begin
      sample_q.data <= sample_i;
      sample_q.last <= sample_last_i;
   end

   assign sample_valid_o = valid_q;
   assign sample_o       = sample_q;

endmodule

`default_nettype wire

// File: src/ca_code_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "corr_macros.svh"

module ca_code_gen
   import corr_pkg::*;
(
   input  logic                              clk,
   input  logic                              rst_n_i,
   input  logic                              clear_i,
   input  logic                              sample_valid_i,
   input  logic [`CORR_CODE_PHASE_WIDTH-1:0] code_inc_i,
   input  ca_taps_t                          prn_taps_i,
   output logic                              ca_bit_o
);

   logic [`CORR_CODE_PHASE_WIDTH-1:0] code_phase_q;
   logic [`CORR_CODE_PHASE_WIDTH:0]   nco_sum;
   logic                              code_carry;
   logic [10:1]                       g1_q;
   logic [10:1]                       g2_q;
   logic                              g1_fb;
   logic                              g2_fb;
   logic [15:0]                       g2_ext;
   logic                              g2_out;

   // A carry out of the code NCO means the next chip is due.
   assign nco_sum    = {1'b0, code_phase_q} + {1'b0, code_inc_i};
   assign code_carry = nco_sum[`CORR_CODE_PHASE_WIDTH];

   assign g1_fb = g1_q[3] ^ g1_q[10];
   assign g2_fb = g2_q[2] ^ g2_q[3] ^ g2_q[6] ^ g2_q[8] ^ g2_q[9] ^ g2_q[10];

   // Stage n of G2 sits at bit n, so a stage number indexes directly.
   // Unused positions read as zero.
   assign g2_ext = {5'd0, g2_q, 1'b0};
   assign g2_out = g2_ext[prn_taps_i.tap_a] ^ g2_ext[prn_taps_i.tap_b];

   // Current Gold chip.
   assign ca_bit_o = g1_q[10] ^ g2_out;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         code_phase_q <= '0;
         g1_q         <= '1;
         g2_q         <= '1;
      end else if (clear_i) begin
         code_phase_q <= '0;
         g1_q         <= '1;
         g2_q         <= '1;
      end else if (sample_valid_i) begin
         code_phase_q <= nco_sum[`CORR_CODE_PHASE_WIDTH-1:0];
         // Step both registers after this sample has used the chip.
         if (code_carry) begin
            g1_q <= {g1_q[9:1], g1_fb};
            g2_q <= {g2_q[9:1], g2_fb};
         end
      end
   end

endmodule

`default_nettype wire

// File: src/carrier_mixer.sv
`timescale 1ns/1ps
`default_nettype none

`include "corr_macros.svh"

module carrier_mixer
   import corr_pkg::*;
(
   input  logic                                  clk,
   input  logic                                  rst_n_i,
   input  logic                                  clear_i,
   input  logic                                  sample_valid_i,
   input  sample_t                               sample_i,
   input  logic                                  ca_bit_i,
   input  logic signed [`CORR_DOPPLER_WIDTH-1:0] doppler_i,
   output mixed_t                                mixed_o
);

   localparam int IDX_W = 3;
   localparam int PAD_W = `CORR_PHASE_WIDTH - `CORR_DOPPLER_WIDTH;

   logic [`CORR_PHASE_WIDTH-1:0]       carrier_inc;
   logic [`CORR_PHASE_WIDTH-1:0]       phase_q;
   logic [IDX_W-1:0]                   carrier_idx;
   logic signed [`CORR_LUT_WIDTH-1:0]  cos_val;
   logic signed [`CORR_LUT_WIDTH-1:0]  sin_val;
   logic signed [`CORR_PROD_WIDTH-1:0] prod_i;
   logic signed [`CORR_PROD_WIDTH-1:0] prod_q;
   logic                               valid_q;
   logic                               last_q;
   logic                               ca_bit_q;
   logic signed [`CORR_PROD_WIDTH-1:0] prod_i_q;
   logic signed [`CORR_PROD_WIDTH-1:0] prod_q_q;

   // IF plus the sign-extended two's complement Doppler.
   assign carrier_inc = `CORR_F_IF_INC + {{PAD_W{doppler_i[`CORR_DOPPLER_WIDTH-1]}}, doppler_i};

   // The table index comes from the phase before this sample's update.
   assign carrier_idx = phase_q[`CORR_PHASE_WIDTH-1 -: IDX_W];

   // Eight-point cosine and sine tables.
   always_comb begin
      case (carrier_idx)
         3'd0: begin cos_val = 3'sd3;  sin_val = 3'sd0;  end
         3'd1: begin cos_val = 3'sd2;  sin_val = 3'sd2;  end
         3'd2: begin cos_val = 3'sd0;  sin_val = 3'sd3;  end
         3'd3: begin cos_val = -3'sd2; sin_val = 3'sd2;  end
         3'd4: begin cos_val = -3'sd3; sin_val = 3'sd0;  end
         3'd5: begin cos_val = -3'sd2; sin_val = -3'sd2; end
         3'd6: begin cos_val = 3'sd0;  sin_val = -3'sd3; end
         default: begin cos_val = 3'sd2; sin_val = -3'sd2; end
      endcase
   end

   assign prod_i = sample_i.data * cos_val;
   assign prod_q = sample_i.data * sin_val;

   // Phase accumulator and the valid flag.
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         phase_q <= '0;
         valid_q <= 1'b0;
      end else if (clear_i) begin
         phase_q <= '0;
         valid_q <= 1'b0;
      end else begin
         valid_q <= sample_valid_i;
         if (sample_valid_i) begin
            phase_q <= phase_q + carrier_inc;
         end
      end
   end

   // Pipeline register for the products, the chip and the last flag.
   always_ff @(posedge clk) begin
      last_q   <= sample_i.last;
      ca_bit_q <= ca_bit_i;
      prod_i_q <= prod_i;
      prod_q_q <= prod_q;
   end

   assign mixed_o.valid  = valid_q;
   assign mixed_o.last   = last_q;
   assign mixed_o.ca_bit = ca_bit_q;
   assign mixed_o.prod_i = prod_i_q;
   assign mixed_o.prod_q = prod_q_q;

endmodule

`default_nettype wire

// File: src/code_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

`include "corr_macros.svh"

module code_accumulator
   import corr_pkg::*;
(
   input  logic                               clk,
   input  logic                               rst_n_i,
   input  logic                               clear_i,
   input  mixed_t                             mixed_i,
   output logic                               dump_valid_o,
   output logic signed [`CORR_ACC_WIDTH-1:0]  sum_i_o,
   output logic signed [`CORR_ACC_WIDTH-1:0]  sum_q_o
);

   localparam int EXT_W = `CORR_ACC_WIDTH - `CORR_PROD_WIDTH;

   logic signed [`CORR_ACC_WIDTH-1:0] prod_i_ext;
   logic signed [`CORR_ACC_WIDTH-1:0] prod_q_ext;
   logic signed [`CORR_ACC_WIDTH-1:0] acc_i_q;
   logic signed [`CORR_ACC_WIDTH-1:0] acc_q_q;
   logic signed [`CORR_ACC_WIDTH-1:0] acc_i_next;
   logic signed [`CORR_ACC_WIDTH-1:0] acc_q_next;
   logic                              dump_valid_q;
   logic                              dump_en;

   assign prod_i_ext = {{EXT_W{mixed_i.prod_i[`CORR_PROD_WIDTH-1]}}, mixed_i.prod_i};
   assign prod_q_ext = {{EXT_W{mixed_i.prod_q[`CORR_PROD_WIDTH-1]}}, mixed_i.prod_q};

   // Chip 1 adds and chip 0 subtracts.
   assign acc_i_next = mixed_i.ca_bit ? acc_i_q + prod_i_ext : acc_i_q - prod_i_ext;
   assign acc_q_next = mixed_i.ca_bit ? acc_q_q + prod_q_ext : acc_q_q - prod_q_ext;

   assign dump_en = mixed_i.valid & mixed_i.last;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         acc_i_q      <= '0;
         acc_q_q      <= '0;
         dump_valid_q <= 1'b0;
      end else if (clear_i) begin
         acc_i_q      <= '0;
         acc_q_q      <= '0;
         dump_valid_q <= 1'b0;
      end else begin
         dump_valid_q <= dump_en;
         if (dump_en) begin
            // The last sample goes into the dump and integration restarts at zero.
            acc_i_q <= '0;
            acc_q_q <= '0;
         end else if (mixed_i.valid) begin
            acc_i_q <= acc_i_next;
            acc_q_q <= acc_q_next;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (dump_en) begin
         sum_i_o <= acc_i_next;
         sum_q_o <= acc_q_next;
      end
   end

   assign dump_valid_o = dump_valid_q;

endmodule

`default_nettype wire

// File: src/result_packer.sv
`timescale 1ns/1ps
`default_nettype none

`include "corr_macros.svh"

module result_packer
   import corr_pkg::*;
(
   input  logic                              clk,
   input  logic                              rst_n_i,
   input  logic                              dump_valid_i,
   input  logic signed [`CORR_ACC_WIDTH-1:0] sum_i_i,
   input  logic signed [`CORR_ACC_WIDTH-1:0] sum_q_i,
   output logic                              result_valid_o,
   output corr_result_t                      result_o
);

   localparam int HEAD_W = `CORR_ACC_WIDTH - `CORR_OUT_WIDTH + 1;

   // Output range limits at accumulator width.
   localparam logic signed [`CORR_ACC_WIDTH-1:0] OUT_MAX =
      {{HEAD_W{1'b0}}, {(`CORR_OUT_WIDTH-1){1'b1}}};
   localparam logic signed [`CORR_ACC_WIDTH-1:0] OUT_MIN =
      {{HEAD_W{1'b1}}, {(`CORR_OUT_WIDTH-1){1'b0}}};

   corr_result_t sat_result;
   corr_result_t result_q;
   logic         valid_q;

   function automatic logic signed [`CORR_OUT_WIDTH-1:0] clamp_sum(
      input logic signed [`CORR_ACC_WIDTH-1:0] sum
   );
      logic signed [`CORR_ACC_WIDTH-1:0] lim;
      lim = sum;
      if (sum > OUT_MAX) begin
         lim = OUT_MAX;
      end else if (sum < OUT_MIN) begin
         lim = OUT_MIN;
      end
      return lim[`CORR_OUT_WIDTH-1:0];
   endfunction

   assign sat_result.corr_i = clamp_sum(sum_i_i);
   assign sat_result.corr_q = clamp_sum(sum_q_i);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= dump_valid_i;
      end
   end

   always_ff @(posedge clk) begin
      if (dump_valid_i) begin
         result_q <= sat_result;
      end
   end

   assign result_valid_o = valid_q;
   assign result_o       = result_q;

endmodule

`default_nettype wire

// File: src/correlator_channel.sv
`timescale 1ns/1ps
`default_nettype none

`include "corr_macros.svh"

module correlator_channel
   import corr_pkg::*;
(
   input  logic                                  clk,
   input  logic                                  rst_n_i,
   input  logic                                  clear_i,
   input  logic                                  sample_valid_i,
   input  logic                                  sample_last_i,
   input  logic signed [`CORR_SAMPLE_WIDTH-1:0]  sample_i,
   input  logic signed [`CORR_DOPPLER_WIDTH-1:0] doppler_i,
   input  logic [`CORR_CODE_PHASE_WIDTH-1:0]     code_inc_i,
   input  ca_taps_t                              prn_taps_i,
   output logic                                  result_valid_o,
   output corr_result_t                          result_o
);

   logic                              sample_valid;
   sample_t                           front_sample;
   logic                              ca_bit;
   mixed_t                            mixed;
   logic                              dump_valid;
   logic signed [`CORR_ACC_WIDTH-1:0] sum_i;
   logic signed [`CORR_ACC_WIDTH-1:0] sum_q;

   sample_front u_sample_front (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .clear_i        (clear_i),
      .sample_valid_i (sample_valid_i),
      .sample_last_i  (sample_last_i),
      .sample_i       (sample_i),
      .sample_valid_o (sample_valid),
      .sample_o       (front_sample)
   );

   // The chip is combinational, so it lines up with the registered sample.
   ca_code_gen u_ca_code_gen (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .clear_i        (clear_i),
      .sample_valid_i (sample_valid),
      .code_inc_i     (code_inc_i),
      .prn_taps_i     (prn_taps_i),
      .ca_bit_o       (ca_bit)
   );

   carrier_mixer u_carrier_mixer (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .clear_i        (clear_i),
      .sample_valid_i (sample_valid),
      .sample_i       (front_sample),
      .ca_bit_i       (ca_bit),
      .doppler_i      (doppler_i),
      .mixed_o        (mixed)
   );

   code_accumulator u_code_accumulator (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .clear_i      (clear_i),
      .mixed_i      (mixed),
      .dump_valid_o (dump_valid),
      .sum_i_o      (sum_i),
      .sum_q_o      (sum_q)
   );

   result_packer u_result_packer (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .dump_valid_i   (dump_valid),
      .sum_i_i        (sum_i),
      .sum_q_i        (sum_q),
      .result_valid_o (result_valid_o),
      .result_o       (result_o)
   );

endmodule

`default_nettype wire

// File: verification/corr_assert.sv
`timescale 1ns/1ps
`default_nettype none

module corr_assert
   import corr_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n_i,
   input  logic         clear_i,
   input  logic         sample_valid_i,
   input  logic         sample_last_i,
   input  logic         result_valid_i,
   input  corr_result_t result_i
);

   // A result strobe drops unless another last sample is due right behind it.
   property strobe_one_cycle;
      @(posedge clk) disable iff (!rst_n_i)
         result_valid_i && !$past(sample_valid_i && sample_last_i, 3) |=> !result_valid_i;
   endproperty

   // A last sample not cut off by clear gives a result 4 cycles later.
   property result_after_last;
      @(posedge clk) disable iff (!rst_n_i)
         $past(sample_valid_i && sample_last_i, 4) && !$past(clear_i, 4) &&
         !$past(clear_i, 3) && !$past(clear_i, 2) |-> result_valid_i;
   endproperty

   property result_known;
      @(posedge clk) disable iff (!rst_n_i)
         result_valid_i |-> !$isunknown(result_i);
   endproperty

   a_strobe_one_cycle: assert property (strobe_one_cycle)
      else $error("result_valid_o stayed high with no second result due");
   a_result_after_last: assert property (result_after_last)
      else $error("no result 4 cycles after a last sample");
   a_result_known: assert property (result_known)
      else $error("result_o has unknown bits while result_valid_o is high");

endmodule

bind correlator_channel corr_assert u_corr_assert (
   .clk            (clk),
   .rst_n_i        (rst_n_i),
   .clear_i        (clear_i),
   .sample_valid_i (sample_valid_i),
   .sample_last_i  (sample_last_i),
   .result_valid_i (result_valid_o),
   .result_i       (result_o)
);

`default_nettype wire

// File: verification/tb_correlator_channel.sv
`timescale 1ns/1ps
`default_nettype none

`include "corr_macros.svh"

module tb_correlator_channel
   import corr_pkg::*;
();

   logic                                  clk;
   logic                                  rst_n_i;
   logic                                  clear_i;
   logic                                  sample_valid_i;
   logic                                  sample_last_i;
   logic signed [`CORR_SAMPLE_WIDTH-1:0]  sample_i;
   logic signed [`CORR_DOPPLER_WIDTH-1:0] doppler_i;
   logic [`CORR_CODE_PHASE_WIDTH-1:0]     code_inc_i;
   ca_taps_t                              prn_taps_i;
   logic                                  result_valid_o;
   corr_result_t                          result_o;

   // Reference model state.
   logic [`CORR_PHASE_WIDTH-1:0]      m_phase;
   logic [`CORR_CODE_PHASE_WIDTH-1:0] m_code_phase;
   logic [10:1]                       m_g1;
   logic [10:1]                       m_g2;
   int                                m_acc_i;
   int                                m_acc_q;
   corr_result_t                      exp_q[$];
   // Bit n set means a result is due n cycles after the current drive edge.
   logic [4:0]                        due_pipe;

   int cos_tab [8] = '{3, 2, 0, -2, -3, -2, 0, 2};
   int sin_tab [8] = '{0, 2, 3, 2, 0, -2, -3, -2};

   correlator_channel u_dut (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .clear_i        (clear_i),
      .sample_valid_i (sample_valid_i),
      .sample_last_i  (sample_last_i),
      .sample_i       (sample_i),
      .doppler_i      (doppler_i),
      .code_inc_i     (code_inc_i),
      .prn_taps_i     (prn_taps_i),
      .result_valid_o (result_valid_o),
      .result_o       (result_o)
   );

   always #2 clk = ~clk;

   task automatic stop_run(input string reason);
      $display("%s", reason);
      $display("SOME TESTS FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic match_result(input corr_result_t got, input corr_result_t exp);
      if (got !== exp) begin
         stop_run($sformatf("Fail at %0t ns: result I %0d Q %0d, expected I %0d Q %0d",
                            $time, got.corr_i, got.corr_q, exp.corr_i, exp.corr_q));
      end
   endtask

   task automatic check_strobe(input logic got, input logic exp);
      if (got !== exp) begin
         stop_run($sformatf("Fail at %0t ns: result_valid_o is %b, expected %b",
                            $time, got, exp));
      end
   endtask

   function automatic logic gold_chip(input logic [10:1] g1, input logic [10:1] g2,
                                      input ca_taps_t taps);
      return g1[10] ^ g2[taps.tap_a] ^ g2[taps.tap_b];
   endfunction

   function automatic int clamp_out(input int v);
      if (v > 32767) begin
         return 32767;
      end
      if (v < -32768) begin
         return -32768;
      end
      return v;
   endfunction

   // Two distinct G2 stages in 1 to 10.
   function automatic ca_taps_t random_taps();
      ca_taps_t t;
      int       a;
      int       b;
      a = int'($urandom_range(10, 1));
      b = ((a - 1 + int'($urandom_range(9, 1))) % 10) + 1;
      t.tap_a = 4'(a);
      t.tap_b = 4'(b);
      return t;
   endfunction

   // Mode 1 keeps the I product positive, mode 2 negative, else random.
   function automatic logic signed [`CORR_SAMPLE_WIDTH-1:0] pick_sample(input int mode);
      int c;
      c = cos_tab[m_phase[15:13]];
      case (mode)
         1: return (c < 0) ? 3'b100 : 3'b011;
         2: return (c < 0) ? 3'b011 : 3'b100;
         default: return 3'($urandom);
      endcase
   endfunction

   task automatic reset_model();
      m_phase      = '0;
      m_code_phase = '0;
      m_g1         = '1;
      m_g2         = '1;
      m_acc_i      = 0;
      m_acc_q      = 0;
   endtask

   task automatic advance_model(input logic signed [`CORR_SAMPLE_WIDTH-1:0] data,
                                input logic last);
      int           idx;
      int           prod_i;
      int           prod_q;
      int           code_sum;
      logic         fb1;
      logic         fb2;
      corr_result_t res;
      idx    = int'(m_phase[15:13]);
      prod_i = int'(data) * cos_tab[idx];
      prod_q = int'(data) * sin_tab[idx];
      if (gold_chip(m_g1, m_g2, prn_taps_i)) begin
         m_acc_i += prod_i;
         m_acc_q += prod_q;
      end else begin
         m_acc_i -= prod_i;
         m_acc_q -= prod_q;
      end
      m_phase = m_phase + `CORR_F_IF_INC + 16'(int'(doppler_i));
      // Chip advance happens only after this sample used the chip.
      code_sum     = int'(m_code_phase) + int'(code_inc_i);
      m_code_phase = 16'(code_sum);
      if (code_sum >= 65536) begin
         fb1  = m_g1[3] ^ m_g1[10];
         fb2  = m_g2[2] ^ m_g2[3] ^ m_g2[6] ^ m_g2[8] ^ m_g2[9] ^ m_g2[10];
         m_g1 = {m_g1[9:1], fb1};
         m_g2 = {m_g2[9:1], fb2};
      end
      if (last) begin
         res.corr_i = 16'(clamp_out(m_acc_i));
         res.corr_q = 16'(clamp_out(m_acc_q));
         exp_q.push_back(res);
         m_acc_i = 0;
         m_acc_q = 0;
      end
   endtask

   // One clock of stimulus, mirrored into the model.
   task automatic drive_cycle(input logic valid, input logic last,
                              input logic signed [`CORR_SAMPLE_WIDTH-1:0] data,
                              input logic clr);
      @(posedge clk);
      sample_valid_i <= valid;
      sample_last_i  <= last;
      sample_i       <= data;
      clear_i        <= clr;
      due_pipe = {due_pipe[3:0], valid & last & ~clr};
      if (clr) begin
         reset_model();
      end else if (valid) begin
         advance_model(data, last);
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) drive_cycle(1'b0, 1'b0, 3'sd0, 1'b0);
   endtask

   // Controls change only once the pipeline holds no samples.
   task automatic set_controls(input logic signed [`CORR_DOPPLER_WIDTH-1:0] dop,
                               input logic [`CORR_CODE_PHASE_WIDTH-1:0] inc,
                               input ca_taps_t taps);
      idle_cycles(3);
      doppler_i  <= dop;
      code_inc_i <= inc;
      prn_taps_i <= taps;
   endtask

   task automatic run_integration(input int len, input int mode, input logic gaps);
      for (int i = 0; i < len; i++) begin
         if (gaps) begin
            idle_cycles(int'($urandom_range(3, 0)));
         end
         drive_cycle(1'b1, i == len - 1, pick_sample(mode), 1'b0);
      end
   endtask

   task automatic drain_results();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 || due_pipe != 5'd0) begin
         if (waited > 32) begin
            stop_run("Timed out waiting for the remaining results to come out.");
         end
         idle_cycles(1);
         waited++;
      end
      idle_cycles(2);
   endtask

   // Outputs are checked on the falling edge, away from the drive edge.
   always @(negedge clk) begin
      if (rst_n_i) begin
         check_strobe(result_valid_o, due_pipe[4]);
         if (result_valid_o && exp_q.size() != 0) begin
            match_result(result_o, exp_q.pop_front());
         end
      end
   end

   initial begin
      void'($urandom(32'h48c8e5e0));
      clk            = 1'b0;
      rst_n_i        = 1'b0;
      clear_i        = 1'b0;
      sample_valid_i = 1'b0;
      sample_last_i  = 1'b0;
      sample_i       = '0;
      doppler_i      = '0;
      code_inc_i     = '0;
      prn_taps_i     = '{tap_a: 4'd2, tap_b: 4'd6};
      due_pipe       = '0;
      reset_model();
      repeat (16) @(posedge clk);
      rst_n_i <= 1'b1;

      // Zero Doppler and a frozen all-ones code.
      set_controls(10'sd0, 16'd0, random_taps());
      repeat (20) run_integration(int'($urandom_range(40, 1)), 0, 1'b0);

      // Doppler of both signs.
      repeat (20) begin
         set_controls(10'($urandom), 16'($urandom), random_taps());
         run_integration(int'($urandom_range(60, 1)), 0, 1'b0);
      end

      // Gold sequence over more than one code period.
      set_controls(10'($urandom), 16'hFFFF, random_taps());
      run_integration(1500, 0, 1'b0);
      repeat (3) begin
         set_controls(10'($urandom), 16'($urandom_range(16'hFFFF, 16'hC000)), random_taps());
         run_integration(1500, 0, 1'b0);
      end

      // Sums beyond the output range in both directions.
      set_controls(10'sd0, 16'd0, random_taps());
      run_integration(6000, 1, 1'b0);
      run_integration(6000, 2, 1'b0);

      // Back-to-back last samples, then random gaps.
      set_controls(10'($urandom), 16'($urandom), random_taps());
      repeat (10) run_integration(1, 0, 1'b0);
      repeat (20) run_integration(int'($urandom_range(8, 1)), 0, 1'b1);

      // Clear in the middle of an integration.
      repeat (4) begin
         set_controls(10'($urandom), 16'($urandom), random_taps());
         repeat (int'($urandom_range(20, 3))) begin
            drive_cycle(1'b1, 1'b0, pick_sample(0), 1'b0);
         end
         drive_cycle(1'b0, 1'b0, 3'sd0, 1'b1);
         run_integration(int'($urandom_range(50, 1)), 0, 1'b0);
      end

      drain_results();
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
+incdir+include
src/corr_pkg.sv
src/sample_front.sv
src/ca_code_gen.sv
src/carrier_mixer.sv
src/code_accumulator.sv
src/result_packer.sv
src/correlator_channel.sv
verification/corr_assert.sv
verification/tb_correlator_channel.sv

// File: Makefile
TOP = tb_correlator_channel

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
